//--- commit_stim.txt
# cmd fields: I op | B we err overlap | A max_ack_delay | W low_cycles | E retires nmis is_store
# op: 0 alu, 1 load, 2 store, 3 fence.i; overlap 1 keeps the response behind the next request
A 3
I 0
I 1
I 2
I 0
B 0 0 0
B 1 0 0
E 4 0 0
W 5
I 3
I 0
I 3
E 7 0 0
B 1 1 0
E 7 1 1
B 0 1 1
B 1 0 0
E 7 2 0
B 1 1 1
B 0 1 0
E 7 3 1
A 0
W 2
I 2
I 3
I 1
E 10 3 1

//--- verilog.f
+incdir+.
ctrl_pkg.sv
commit_if.sv
instr_decode.sv
bus_err_tracker.sv
commit_fsm.sv
commit_ctrl_top.sv
tb_commit_ctrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_commit_ctrl -o sim_commit_ctrl

out=$(./obj_dir/sim_commit_ctrl)
echo "$out"

# Exits non-zero when the pass line is missing
echo "$out" | grep -qx "Regression passed"

//--- tb_checks.svh
/*
 * Error counters, check and report tasks for the commit controller testbench
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Wrong values seen by the checks, and protocol or sequencing faults
int value_errs = 0;
int proto_errs = 0;

// Compares one observed value with the value the testbench model expects
task automatic check_eq(input string what, input int got, input int exp);
  if (got != exp) begin
    value_errs++;
    $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
  end
endtask

// Records a fault that has no single expected value
task automatic report_fault(input string msg);
  proto_errs++;
  $display("Problem at %0t ns: %s", $time, msg);
endtask

// While reset is active, none of the commit outputs may be high
task automatic check_reset_quiet();
  if (pc_set_o || retire_o || fencei_flush_req_o || instr_credit_o || nmi_is_store_o) begin
    report_fault("an output is high while reset is active");
  end
endtask

// Flush request rules are sampled once per cycle on the falling edge
task automatic check_fencei_step(input logic req_was, input logic ack_was);
  if (fencei_flush_req_o && !wbuf_empty_i) begin
    report_fault("flush request is high while the write buffer is not empty");
  end
  if (req_was && !ack_was && !fencei_flush_req_o) begin
    report_fault("flush request fell without an acknowledge");
  end
  // Request and acknowledge met at the last edge, so fetch restarts now
  if (req_was && ack_was) begin
    if (fencei_flush_req_o) begin
      report_fault("flush request stayed high after the acknowledge");
    end
    if (!(pc_set_o && pc_mux_o == PC_FENCEI && retire_o)) begin
      report_fault("no fence.i PC set and retirement after the handshake");
    end
  end
endtask

`endif

//--- tb_commit_ctrl.sv
/*
 * Testbench for the commit controller: stimulus file reader, bus and
 * fence.i responders, output monitor with reference model, watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_commit_ctrl;

  import ctrl_pkg::*;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic instr_valid_i = 1'b0;
  opcode_e instr_op_i = OP_ALU;
  logic obi_req_i = 1'b0;
  logic obi_gnt_i = 1'b0;
  logic obi_we_i = 1'b0;
  logic obi_rvalid_i = 1'b0;
  logic obi_err_i = 1'b0;
  logic wbuf_empty_i = 1'b1;
  logic fencei_flush_ack_i = 1'b0;
  logic instr_credit_o;
  logic fencei_flush_req_o;
  logic pc_set_o;
  pc_mux_e pc_mux_o;
  logic retire_o;
  logic nmi_is_store_o;

  `include "tb_checks.svh"

  // Reference model state
  string   stim_lines[$];
  opcode_e sent_ops[$];
  logic    outst_we[$];
  logic    outst_err[$];
  int  n_lines = 0;
  int  credits = INSTR_CREDITS;
  int  retire_cnt = 0;
  int  nmi_cnt = 0;
  int  boot_cnt = 0;
  int  model_nmis = 0;
  int  ack_max = 0;
  int  wbuf_low = 0;
  int  seed = 5161;
  logic model_pend = 1'b0;
  logic model_store = 1'b0;
  logic req_was = 1'b0;
  logic ack_was = 1'b0;

  commit_ctrl_top u_dut (.*);

  initial begin
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Monitor
  //////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      check_reset_quiet();
    end else begin
      check_fencei_step(req_was, ack_was);
      if (instr_credit_o) credits++;
      if (credits > INSTR_CREDITS) report_fault("more credits returned than sent");
      if (pc_set_o && pc_mux_o == PC_BOOT) boot_cnt++;
      if (pc_set_o && pc_mux_o == PC_TRAP_NMI) begin
        nmi_cnt++;
        if (!model_pend) report_fault("NMI taken with no error pending");
        model_pend = 1'b0;
      end
      if (retire_o) begin
        retire_cnt++;
        if (boot_cnt != 1) report_fault("retirement before the boot PC set");
        if (sent_ops.size() == 0) begin
          report_fault("retirement with no instruction sent");
        end else begin
          // A fence.i head may only leave together with its PC set
          check_eq("fence.i at head on retire", int'(sent_ops[0] == OP_FENCEI),
                   int'(pc_set_o && pc_mux_o == PC_FENCEI));
          void'(sent_ops.pop_front());
        end
      end
      req_was = fencei_flush_req_o;
      ack_was = fencei_flush_ack_i;
    end
  end

  // Flush acknowledge comes after a random delay
  initial begin
    forever begin
      @(negedge clk);
      if (fencei_flush_req_o) begin
        repeat ($unsigned($random(seed)) % (ack_max + 1)) @(posedge clk);
        @(posedge clk);
        fencei_flush_ack_i <= 1'b1;
        @(posedge clk);
        fencei_flush_ack_i <= 1'b0;
      end
    end
  end

  // Write buffer reads as not empty for W cycles
  always @(posedge clk) begin
    wbuf_empty_i <= (wbuf_low == 0);
    if (wbuf_low > 0) wbuf_low--;
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic send_instr(input int op);
    @(posedge clk);
    while (credits == 0) @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_op_i    <= opcode_e'(op[1:0]);
    credits--;
    sent_ops.push_back(opcode_e'(op[1:0]));
    @(posedge clk);
    instr_valid_i <= 1'b0;
  endtask

  // Responses come in order and each one belongs to the oldest request
  task automatic drain_bus();
    while (outst_we.size() > 0) begin
      obi_rvalid_i <= 1'b1;
      obi_err_i    <= outst_err[0];
      if (outst_err[0] && !model_pend) begin
        model_pend  = 1'b1;
        model_store = outst_we[0];
        model_nmis++;
      end
      void'(outst_we.pop_front());
      void'(outst_err.pop_front());
      @(posedge clk);
    end
    obi_rvalid_i <= 1'b0;
    obi_err_i    <= 1'b0;
  endtask

  task automatic bus_xfer(input int we, input int err, input int overlap);
    @(posedge clk);
    obi_req_i <= 1'b1;
    obi_gnt_i <= 1'b1;
    obi_we_i  <= we[0];
    outst_we.push_back(we[0]);
    outst_err.push_back(err[0]);
    @(posedge clk);
    obi_req_i <= 1'b0;
    obi_gnt_i <= 1'b0;
    if (overlap == 0 || outst_we.size() >= MAX_OUTSTANDING) drain_bus();
  endtask

  task automatic check_totals(input int e_ret, input int e_nmi, input int e_store);
    @(negedge clk);
    while (sent_ops.size() != 0 || model_pend) @(negedge clk);
    repeat (3) @(negedge clk);
    check_eq("retire count", retire_cnt, e_ret);
    check_eq("NMI count", nmi_cnt, e_nmi);
    check_eq("modelled NMI count", model_nmis, e_nmi);
    check_eq("nmi_is_store_o", int'(nmi_is_store_o), int'(model_store));
    check_eq("nmi_is_store_o from file", int'(nmi_is_store_o), e_store);
    check_eq("idle credits", credits, INSTR_CREDITS);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  task automatic load_stim();
    int    fd;
    string line;
    fd = $fopen("commit_stim.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") stim_lines.push_back(line);
      end
      $fclose(fd);
    end
    n_lines = stim_lines.size();
  endtask

  task automatic run_all();
    byte cmd;
    int  f0;
    int  f1;
    int  f2;
    foreach (stim_lines[i]) begin
      f0 = 0;
      f1 = 0;
      f2 = 0;
      void'($sscanf(stim_lines[i], "%c %d %d %d", cmd, f0, f1, f2));
      case (cmd)
        "I": send_instr(f0);
        "B": bus_xfer(f0, f1, f2);
        "A": ack_max = f0;
        "W": wbuf_low = f0;
        "E": check_totals(f0, f1, f2);
        default: report_fault("unknown command in stimulus file");
      endcase
    end
  endtask

  initial begin
    load_stim();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    if (n_lines > 0) run_all();
    else report_fault("stimulus file commit_stim.txt missing or empty");
    check_eq("boot PC sets", boot_cnt, 1);
    $display("Errors: %0d wrong values, %0d protocol faults", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from the stimulus length
  initial begin
    wait (n_lines > 0);
    #(n_lines * 200 * 8);
    $display("Watchdog expired before the stimulus finished");
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- commit_ctrl_top.sv
/*
 * Commit controller top: queue, bus-error tracker and commit FSM
 */
`timescale 1ns/1ps
`default_nettype none

module commit_ctrl_top (
  input  logic              clk,
  input  logic              rst_n,

  // Credit-based instruction intake
  input  logic              instr_valid_i,
  input  ctrl_pkg::opcode_e instr_op_i,
  output logic              instr_credit_o,

  // Data-bus observation
  input  logic              obi_req_i,
  input  logic              obi_gnt_i,
  input  logic              obi_we_i,
  input  logic              obi_rvalid_i,
  input  logic              obi_err_i,

  // Fence.i handshake
  input  logic              wbuf_empty_i,
  input  logic              fencei_flush_ack_i,
  output logic              fencei_flush_req_o,

  // Commit results
  output logic              pc_set_o,
  output ctrl_pkg::pc_mux_e pc_mux_o,
  output logic              retire_o,
  output logic              nmi_is_store_o
);

  // Latch status toward the FSM and the clear pulse back
  logic nmi_pending;
  logic nmi_taken;

  commit_if u_commit_if ();

  //////////////////////////////
  // Units
  //////////////////////////////

  instr_decode u_instr_decode (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .instr_op_i     (instr_op_i),
    .instr_credit_o (instr_credit_o),
    .c              (u_commit_if.decode)
  );

  bus_err_tracker u_bus_err_tracker (
    .clk            (clk),
    .rst_n          (rst_n),
    .obi_req_i      (obi_req_i),
    .obi_gnt_i      (obi_gnt_i),
    .obi_we_i       (obi_we_i),
    .obi_rvalid_i   (obi_rvalid_i),
    .obi_err_i      (obi_err_i),
    .nmi_taken_i    (nmi_taken),
    .nmi_pending_o  (nmi_pending),
    .nmi_is_store_o (nmi_is_store_o)
  );

  commit_fsm u_commit_fsm (
    .clk                (clk),
    .rst_n              (rst_n),
    .c                  (u_commit_if.commit),
    .nmi_pending_i      (nmi_pending),
    .wbuf_empty_i       (wbuf_empty_i),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .fencei_flush_req_o (fencei_flush_req_o),
    .nmi_taken_o        (nmi_taken),
    .pc_set_o           (pc_set_o),
    .pc_mux_o           (pc_mux_o),
    .retire_o           (retire_o)
  );

endmodule

`default_nettype wire

//--- commit_fsm.sv
/*
 * Commit state machine: boot PC set, fence.i flush handshake, NMI take
 * and in-order retirement of the writeback instruction
 */
`timescale 1ns/1ps
`default_nettype none

module commit_fsm (
  input  logic              clk,
  input  logic              rst_n,
  commit_if.commit          c,
  input  logic              nmi_pending_i,
  input  logic              wbuf_empty_i,
  input  logic              fencei_flush_ack_i,
  output logic              fencei_flush_req_o,
  output logic              nmi_taken_o,
  output logic              pc_set_o,
  output ctrl_pkg::pc_mux_e pc_mux_o,
  output logic              retire_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  logic head_plain;
  logic head_fencei_go;

  // ALU ops retire at once, and so do loads and stores
  // Their bus responses are followed separately by the error tracker
  assign head_plain = c.valid && (c.is_lsu || !c.is_fencei);

  // A fence.i may start its handshake only once the write buffer has drained
  assign head_fencei_go = c.valid && c.is_fencei && wbuf_empty_i;

  //////////////////////////////
  // State register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Next state and outputs
  //////////////////////////////

  always_comb begin
    state_d     = state_q;
    pc_set_o    = 1'b0;
    pc_mux_o    = PC_BOOT;
    nmi_taken_o = 1'b0;
    c.retire    = 1'b0;

    case (state_q)
      ST_RESET: begin
        // One idle cycle after reset release before the boot jump
        state_d = ST_BOOT_SET;
      end
      ST_BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = ST_FUNCTIONAL;
      end
      ST_FUNCTIONAL: begin
        if (nmi_pending_i) begin
          // NMI wins over the head, which stays put for the handler to follow
          pc_set_o    = 1'b1;
          pc_mux_o    = PC_TRAP_NMI;
          nmi_taken_o = 1'b1;
        end else if (head_plain) begin
          c.retire = 1'b1;
        end else if (head_fencei_go) begin
          state_d = ST_FENCEI_REQ;
        end
      end
      ST_FENCEI_REQ: begin
        // Request is held until the edge that samples the acknowledge
        if (fencei_flush_ack_i) begin
          state_d = ST_FENCEI_DONE;
        end
      end
      ST_FENCEI_DONE: begin
        // Fence.i retires and fetch restarts behind it
        c.retire = 1'b1;
        pc_set_o = 1'b1;
        pc_mux_o = PC_FENCEI;
        state_d  = ST_FUNCTIONAL;
      end
      default: begin
        state_d = ST_RESET;
      end
    endcase
  end

  // Request comes straight from the state, so it rises and falls on edges only
  assign fencei_flush_req_o = (state_q == ST_FENCEI_REQ);

  assign retire_o = c.retire;

endmodule

`default_nettype wire

//--- bus_err_tracker.sv
/*
 * Data-bus observer that tracks the type of each outstanding transaction
 * and latches whether the first error response came from a load or a store
 */
`timescale 1ns/1ps
`default_nettype none

module bus_err_tracker (
  input  logic clk,
  input  logic rst_n,
  input  logic obi_req_i,
  input  logic obi_gnt_i,
  input  logic obi_we_i,
  input  logic obi_rvalid_i,
  input  logic obi_err_i,
  input  logic nmi_taken_i,
  output logic nmi_pending_o,
  output logic nmi_is_store_o
);

  import ctrl_pkg::*;

  // Write-enable per outstanding transaction
  // Bit 0 holds the newest request, higher bits hold older ones
  logic [MAX_OUTSTANDING-1:0] outst_type_q;
  logic [OUTST_W-1:0]         outst_cnt_q;

  logic accept;
  logic oldest_we;
  logic first_err;

  // A request only counts once the bus has granted it
  assign accept = obi_req_i && obi_gnt_i;

  //////////////////////////////
  // Outstanding tracking
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_type_q <= '0;
      outst_cnt_q  <= '0;
    end else begin
      // Every accepted request shifts in its type
      // The entry a response retires simply ages out of the counted range
      if (accept) begin
        outst_type_q <= {outst_type_q[MAX_OUTSTANDING-2:0], obi_we_i};
      end
      if (accept && !obi_rvalid_i) begin
        outst_cnt_q <= outst_cnt_q + OUTST_W'(1);
      end else if (!accept && obi_rvalid_i) begin
        outst_cnt_q <= outst_cnt_q - OUTST_W'(1);
      end
    end
  end

  // Responses come in order, so the one on the bus belongs to the oldest entry
  assign oldest_we = (outst_cnt_q == OUTST_W'(1)) ? outst_type_q[0]
                                                  : outst_type_q[MAX_OUTSTANDING-1];

  //////////////////////////////
  // First-error latch
  //////////////////////////////

  // Only an error that finds no NMI pending gets recorded
  assign first_err = obi_rvalid_i && obi_err_i && !nmi_pending_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nmi_pending_o  <= 1'b0;
      nmi_is_store_o <= 1'b0;
    end else begin
      if (first_err) begin
        nmi_pending_o  <= 1'b1;
        nmi_is_store_o <= oldest_we;
      end else if (nmi_taken_i) begin
        // The type stays visible until the next error replaces it
        nmi_pending_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- instr_decode.sv
/*
 * Credit-based two-entry instruction queue with head opcode decode
 */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid_i,
  input  ctrl_pkg::opcode_e instr_op_i,
  output logic              instr_credit_o,
  commit_if.decode          c
);

  import ctrl_pkg::*;

  // Opcode storage, one slot per credit
  opcode_e                          queue_q [INSTR_CREDITS];
  logic [$clog2(INSTR_CREDITS)-1:0] rd_ptr_q;
  logic [$clog2(INSTR_CREDITS)-1:0] wr_ptr_q;
  logic [CREDIT_W-1:0]              count_q;

  opcode_e head_op;
  logic    push;
  logic    pop;

  // The sender only drives valid while it holds a credit, so a push always has room
  assign push = instr_valid_i;
  assign pop  = c.retire && c.valid;

  //////////////////////////////
  // Storage and pointers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      queue_q[wr_ptr_q] <= instr_op_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Occupancy holds when a push and a pop meet
      if (push && !pop) begin
        count_q <= count_q + CREDIT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CREDIT_W'(1);
      end
    end
  end

  //////////////////////////////
  // Head decode
  //////////////////////////////

  assign head_op = queue_q[rd_ptr_q];

  // An entry written at an edge is visible here from the next cycle on
  assign c.valid     = (count_q != '0);
  // Flags are masked with valid so an empty slot never shows stale contents
  assign c.is_lsu    = c.valid && ((head_op == OP_LOAD) || (head_op == OP_STORE));
  assign c.is_fencei = c.valid && (head_op == OP_FENCEI);

  // Each pop frees one slot, so the credit goes back in the same cycle
  assign instr_credit_o = pop;

endmodule

`default_nettype wire

//--- commit_if.sv
/*
 * Writeback-stage channel from the instruction queue to the commit FSM
 */
`timescale 1ns/1ps
`default_nettype none

interface commit_if;

  // Head entry of the queue is on offer while this is high
  logic valid;

  // Head is a load or a store
  logic is_lsu;

  // Head is a fence.i, which has to wait for the flush handshake
  logic is_fencei;

  // The FSM consumes the head in this cycle
  // The queue pops on it and hands one credit back to the sender
  logic retire;

  // Queue side
  modport decode (
    output valid,
    output is_lsu,
    output is_fencei,
    input  retire
  );

  // FSM side
  modport commit (
    input  valid,
    input  is_lsu,
    input  is_fencei,
    output retire
  );

endinterface

`default_nettype wire

//--- ctrl_pkg.sv
/*
 * Shared types and sizes for the commit-stage controller: opcode, FSM state
 * and PC source enums, plus queue and bus tracker sizing
 */
`default_nettype none

package ctrl_pkg;

  //////////////////////////////
  // Sizing
  //////////////////////////////

  // Queue depth, which is also the number of credits the sender owns after reset
  localparam int unsigned INSTR_CREDITS = 2;
  // Credit and occupancy counter width, enough for 0 to INSTR_CREDITS
  localparam int unsigned CREDIT_W = 2;

  // Data-bus transactions that may be in flight at once
  localparam int unsigned MAX_OUTSTANDING = 2;
  // Outstanding counter width, enough for 0 to MAX_OUTSTANDING
  localparam int unsigned OUTST_W = 2;

  //////////////////////////////
  // Enumerations
  //////////////////////////////

  // Instruction class as seen by the commit stage
  typedef enum logic [1:0] {
    OP_ALU    = 2'b00,
    OP_LOAD   = 2'b01,
    OP_STORE  = 2'b10,
    OP_FENCEI = 2'b11
  } opcode_e;

  // Commit FSM states
  typedef enum logic [2:0] {
    ST_RESET       = 3'd0,
    ST_BOOT_SET    = 3'd1,
    ST_FUNCTIONAL  = 3'd2,
    ST_FENCEI_REQ  = 3'd3,
    ST_FENCEI_DONE = 3'd4
  } ctrl_state_e;

  // Source of the new PC on a PC set
  typedef enum logic [1:0] {
    PC_BOOT     = 2'b00,
    PC_FENCEI   = 2'b01,
    PC_TRAP_NMI = 2'b10
  } pc_mux_e;

endpackage

`default_nettype wire
